// File: bench/mcseq_assertions.sv
/*
 * sequencer protocol checker, bound into mcseq_top
 * reset state, busy/done timing, abort, command gating and word spacing
 */
`timescale 1ns/10ps
`default_nettype none

module mcseq_assertions import mcseq_pkg::*; (
    input logic        mclk,
    input logic        mrst,
    input logic        run_seq_i,
    input logic        busy_i,
    input logic        done_i,
    input logic        buf_rd_i,
    input logic        buf_wr_i,
    input ddr_cmd_t    ddr_cmd_i,
    input ddr_ctrl_t   ctrl_i,
    input logic        word_valid_i,
    input cmd_fields_t fields_i
);

    int                 fail_cnt = 0;  // failed assertion count
    logic               in_run;        // a word of this run already seen
    logic [PAUSE_W-1:0] gap;           // idle cycles since that word
    logic [PAUSE_W-1:0] exp_gap;       // idle cycles the word asked for

    always_ff @(posedge mclk) begin
        if (mrst || ctrl_i.ddr_rst) begin
            in_run  <= 1'b0;
            gap     <= '0;
            exp_gap <= '0;
        end else if (word_valid_i) begin
            in_run  <= !fields_i.done;  // done word closes the run
            gap     <= '0;
            exp_gap <= fields_i.nop ? fields_i.pause_len : PAUSE_W'(fields_i.add_pause);
        end else if (in_run) begin
            gap <= gap + 1'b1;
        end
    end

    a_reset_state: assert property (@(posedge mclk) mrst |=> !busy_i && !done_i &&
            !buf_rd_i && !buf_wr_i && ddr_cmd_i.op == OP_NOP)
        else begin fail_cnt++; $error("outputs left the reset state"); end
    a_busy_rise: assert property (@(posedge mclk) disable iff (mrst)
            run_seq_i && !ctrl_i.ddr_rst |=> busy_i)
        else begin fail_cnt++; $error("busy did not rise after run_seq"); end
    a_done_fall: assert property (@(posedge mclk) disable iff (mrst)
            done_i |-> !busy_i && $past(busy_i))
        else begin fail_cnt++; $error("done without busy falling"); end
    a_done_pulse: assert property (@(posedge mclk) disable iff (mrst) done_i |=> !done_i)
        else begin fail_cnt++; $error("done longer than one cycle"); end
    a_abort: assert property (@(posedge mclk) disable iff (mrst)
            ctrl_i.ddr_rst |=> !busy_i && !done_i)
        else begin fail_cnt++; $error("sequencer not cleared by ddr_rst"); end
    a_cmd_gate: assert property (@(posedge mclk) disable iff (mrst)
            !ctrl_i.cmda_en |=> ddr_cmd_i.op == OP_NOP)
        else begin fail_cnt++; $error("command out while cmda_en low"); end
    a_word_gap: assert property (@(posedge mclk) disable iff (mrst)
            word_valid_i && in_run |-> gap == exp_gap)
        else begin fail_cnt++; $error("word spacing %0d, expected %0d", gap, exp_gap); end

endmodule

bind mcseq_top mcseq_assertions u_assertions (
    .mclk         (mclk),
    .mrst         (mrst),
    .run_seq_i    (run_seq_i),
    .busy_i       (run_busy_o),
    .done_i       (run_done_o),
    .buf_rd_i     (buf_rd_o),
    .buf_wr_i     (buf_wr_o),
    .ddr_cmd_i    (ddr_cmd_o),
    .ctrl_i       (ddr_ctrl_o),
    .word_valid_i (word_valid),
    .fields_i     (fields)
);

`default_nettype wire

// File: bench/mcseq_tb.sv
/*
 * testbench for the DDR3 command sequencer
 * LFSR drawn programs in both banks, pin stream and write delay checks,
 * control flags, abort and command gating
 */
`timescale 1ns/10ps
`default_nettype none

module mcseq_tb import mcseq_pkg::*; ();

    localparam int PROG_LEN     = 12;  // words before the done word
    localparam int MAX_PAUSE    = 7;   // 3-bit pause draw
    localparam int RUN_LIMIT    = (PROG_LEN + 1) * (MAX_PAUSE + 1) + 8;
    localparam int WATCHDOG_CYC = 4 * RUN_LIMIT + 600;  // four runs plus setup

    typedef struct packed {
        ddr_cmd_t cmd;  // DDR pins of this cycle
        logic     rd;
        logic     wr;
        logic     rst;  // page reset
    } pin_exp_t;

    logic                mclk;
    logic                mrst;
    logic [7:0]          cmd_ad_i;
    logic                cmd_stb_i;
    bank_wr_t            bank_wr_i;
    logic                run_seq_i;
    logic [CMD_ADDR_W:0] run_addr_i;
    buf_tag_t            run_chn_i;
    logic                run_busy_o;
    logic                run_done_o;
    logic                mcontr_reset_o;
    ddr_cmd_t            ddr_cmd_o;
    ddr_ctrl_t           ddr_ctrl_o;
    logic                buf_rd_o;
    logic                buf_rpage_nxt_o;
    buf_tag_t            buf_rchn_o;
    logic                buf_wr_o;
    logic                buf_wpage_nxt_o;
    buf_tag_t            buf_wchn_o;

    logic [15:0] lfsr = 16'h0001;  // seed
    pin_exp_t    exp_q [$];        // expected pins per pin cycle
    int          errors = 0;
    int          tests = 0;
    int          failed = 0;
    int          mark = 0;
    int          wdly = DFLT_WBUF_DELAY;

    mcseq_top u_mcseq_top (.*);

    initial begin
        mclk = 1'b0;
        forever #10 mclk = ~mclk;
    end

    initial begin
        #(WATCHDOG_CYC * 20);
        $display("watchdog timeout, the tests did not finish in time");
        $display("Finished with errors");
        $finish;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);  // x^16+x^14+x^13+x^11+1
    endfunction

    task automatic draw(input int nbits, output int val);
        val = 0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_next(lfsr);  // one step per bit
            val  = (val << 1) | lfsr[0];
        end
    endtask

    function automatic int total_errors();
        return errors + u_mcseq_top.u_assertions.fail_cnt;
    endfunction

    // NOP on the pins, all buffer strobes low
    function automatic pin_exp_t idle_pins();
        pin_exp_t p;
        p        = '0;
        p.cmd.op = OP_NOP;
        return p;
    endfunction

    task automatic expect_eq(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic report(input string name);
        tests++;
        if (total_errors() != mark) failed++;
        $display("test %0d %s: %s", tests, name, (total_errors() != mark) ? "failed" : "ok");
        mark = total_errors();
    endtask

    // AL with strobe, AH, then D0/D1 for the 16-bit group
    task automatic send_cmd(input logic [10:0] addr, input logic [15:0] data, input bit wide);
        @(negedge mclk);
        cmd_stb_i = 1'b1;
        cmd_ad_i  = addr[7:0];
        @(negedge mclk);
        cmd_stb_i = 1'b0;
        cmd_ad_i  = {5'd0, addr[10:8]};
        if (wide) begin
            @(negedge mclk);
            cmd_ad_i = data[7:0];
            @(negedge mclk);
            cmd_ad_i = data[15:8];
        end
        @(negedge mclk);
        cmd_ad_i = '0;  // returns one cycle before the write lands
    endtask

    task automatic write_word(input logic bank, input int addr, input cmd_word_t w);
        @(negedge mclk);
        bank_wr_i.we   = 1'b1;
        bank_wr_i.bank = bank;
        bank_wr_i.addr = CMD_ADDR_W'(addr);
        bank_wr_i.data = w;
    endtask

    // random program plus done word, expected pins from the spacing rule
    task automatic load_program(input logic bank, input int start);
        int        v;
        cmd_word_t w;
        exp_q.delete();
        for (int i = 0; i <= PROG_LEN; i++) begin
            w = '0;
            draw(3, v);
            if (i == PROG_LEN) begin
                w.op   = OP_NOP;
                w.addr = 15'h400 | 15'(v);  // done, pause field ignored
                exp_q.push_back(idle_pins());
            end else if (v >= 6) begin
                w.op = OP_NOP;
                draw(3, v);
                w.addr = 15'(v);  // pause length
                repeat (v + 1) exp_q.push_back(idle_pins());
            end else begin
                w.op = ddr_op_e'(v);  // 0..5 are the non-NOP opcodes
                draw(3, v);
                w.ba = 3'(v);
                draw(15, v);
                w.addr = 15'(v);
                draw(5, v);
                {w.odt, w.buf_rd, w.buf_wr, w.buf_rst, w.add_pause} = 5'(v);
                exp_q.push_back({w.op, w.ba, w.addr, w.odt, w.buf_rd, w.buf_wr, w.buf_rst});
                if (w.add_pause) exp_q.push_back(idle_pins());
            end
            write_word(bank, start + i, w);
        end
        @(negedge mclk);
        bank_wr_i.we = 1'b0;
    endtask

    task automatic start_run(input logic bank, input int start, input logic [3:0] chn);
        @(negedge mclk);
        run_seq_i     = 1'b1;
        run_addr_i    = {bank, CMD_ADDR_W'(start)};
        run_chn_i.chn = chn;
        @(negedge mclk);
        run_seq_i = 1'b0;
    endtask

    task automatic check_stream(input logic [3:0] chn);
        pin_exp_t e;
        pin_exp_t d;
        expect_eq(run_busy_o, 1, "run_busy_o one cycle after run_seq_i");
        expect_eq(buf_rchn_o.chn, chn, "buf_rchn_o latched at run_seq_i");
        repeat (2) @(negedge mclk);  // first word on the pins
        for (int k = 0; k < exp_q.size() + wdly + 1; k++) begin
            if (k < exp_q.size()) begin
                e = exp_q[k];
                expect_eq(ddr_cmd_o, e.cmd, $sformatf("ddr_cmd_o in pin cycle %0d", k));
                expect_eq(buf_rd_o, e.rd, "buf_rd_o");
                expect_eq(buf_rpage_nxt_o, e.rst, "buf_rpage_nxt_o");
                expect_eq(run_done_o, k == exp_q.size() - 1, "run_done_o");
            end
            d = (k > wdly) ? exp_q[k-wdly-1] : idle_pins();  // delay+1 behind the pins
            expect_eq(buf_wr_o, d.wr, "buf_wr_o after the write delay");
            expect_eq(buf_wpage_nxt_o, d.rst, "buf_wpage_nxt_o after the write delay");
            if (d.wr || d.rst) expect_eq(buf_wchn_o.chn, chn, "buf_wchn_o");
            @(negedge mclk);
        end
        expect_eq(run_busy_o, 0, "run_busy_o after done");
    endtask

    initial begin
        mrst       = 1'b1;
        cmd_ad_i   = '0;
        cmd_stb_i  = 1'b0;
        bank_wr_i  = '0;
        run_seq_i  = 1'b0;
        run_addr_i = '0;
        run_chn_i  = '0;
        repeat (5) @(negedge mclk);
        mrst = 1'b0;

        @(negedge mclk);
        expect_eq({run_busy_o, run_done_o, buf_rd_o, buf_wr_o}, 0, "strobes after reset");
        expect_eq(ddr_cmd_o.op, OP_NOP, "ddr_cmd_o after reset");
        expect_eq(ddr_ctrl_o, 3'b010, "control flags after reset");
        expect_eq(mcontr_reset_o, 1, "mcontr_reset_o after reset");
        report("reset state");

        send_cmd(11'h025, 16'h0000, 1'b0);  // cmda_en on
        expect_eq(ddr_ctrl_o.cmda_en, 0, "cmda_en one cycle early");
        @(negedge mclk);
        expect_eq(ddr_ctrl_o.cmda_en, 1, "cmda_en 2 cycles after strobe");
        send_cmd(11'h026, 16'h0000, 1'b0);  // memory reset off
        send_cmd(11'h029, 16'h0000, 1'b0);  // cke on
        send_cmd(11'h034, 16'h0000, 1'b0);  // outside the group
        @(negedge mclk);
        expect_eq(ddr_ctrl_o, 3'b101, "flags after non-matching command");
        expect_eq(mcontr_reset_o, 0, "mcontr_reset_o after memory reset off");
        report("control flags");

        send_cmd(11'h052, 16'd3, 1'b1);
        expect_eq(u_mcseq_top.wbuf_delay, DFLT_WBUF_DELAY, "write delay one cycle early");
        @(negedge mclk);
        expect_eq(u_mcseq_top.wbuf_delay, 3, "write delay 4 cycles after strobe");
        wdly = 3;
        report("write delay register");

        load_program(1'b0, 16);
        start_run(1'b0, 16, 4'h5);
        check_stream(4'h5);
        report("program in bank 0");

        send_cmd(11'h052, 16'd11, 1'b1);
        wdly = 11;
        load_program(1'b1, 40);
        start_run(1'b1, 40, 4'ha);
        check_stream(4'ha);
        report("program in bank 1");

        start_run(1'b0, 16, 4'h3);
        send_cmd(11'h027, 16'h0000, 1'b0);  // memory reset on mid-run
        expect_eq(run_busy_o, 1, "run_busy_o before the abort");
        repeat (2) @(negedge mclk);
        expect_eq(run_busy_o, 0, "run_busy_o after ddr_rst");
        expect_eq(mcontr_reset_o, 1, "mcontr_reset_o after ddr_rst");
        repeat (RUN_LIMIT) begin
            expect_eq(run_done_o, 0, "run_done_o after the abort");
            @(negedge mclk);
        end
        send_cmd(11'h024, 16'h0000, 1'b0);  // command outputs off
        send_cmd(11'h026, 16'h0000, 1'b0);
        start_run(1'b1, 40, 4'h6);
        for (int n = 0; n < RUN_LIMIT && !run_done_o; n++) begin
            expect_eq(ddr_cmd_o.op, OP_NOP, "ddr_cmd_o with cmda_en low");
            @(negedge mclk);
        end
        if (!run_done_o) begin
            $display("the run with cmda_en low did not finish");
            errors++;
        end
        report("abort and command gating");

        $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests, failed, errors, u_mcseq_top.u_assertions.fail_cnt);
        if (total_errors() == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
hdl/mcseq_pkg.sv
hdl/cmd_deser.sv
hdl/phy_ctrl_regs.sv
hdl/seq_fetch_ctrl.sv
hdl/cmd_bank_ram.sv
hdl/cmd_word_decode.sv
hdl/buf_wr_delay.sv
hdl/mcseq_top.sv
bench/mcseq_assertions.sv
bench/mcseq_tb.sv

// File: hdl/buf_wr_delay.sv
/*
 * write buffer strobe delay
 * 16-deep shift line for write strobe, page reset and channel tag,
 * tapped for delay_i+1 cycles
 */
`timescale 1ns/10ps
`default_nettype none

module buf_wr_delay import mcseq_pkg::*; (
    input  logic       mclk,
    input  logic       mrst,
    input  logic [3:0] delay_i,
    input  logic       wr_i,
    input  logic       rst_i,
    input  buf_tag_t   tag_i,
    output logic       wr_o,
    output logic       rst_o,
    output buf_tag_t   tag_o
);

    logic [1:0] ctl_sr [16];  // {wr, rst} per stage
    buf_tag_t   tag_sr [16];

    always_ff @(posedge mclk) begin
        if (mrst) begin
            ctl_sr <= '{default: '0};
        end else begin
            ctl_sr[0] <= {wr_i, rst_i};
            for (int k = 1; k < $size(ctl_sr); k++) begin
                ctl_sr[k] <= ctl_sr[k-1];
            end
        end
    end

    always_ff @(posedge mclk) begin
        tag_sr[0] <= tag_i;
        for (int k = 1; k < $size(tag_sr); k++) begin
            tag_sr[k] <= tag_sr[k-1];
        end
    end

    assign {wr_o, rst_o} = ctl_sr[delay_i];  // tap 0 is one cycle
    assign tag_o         = tag_sr[delay_i];

endmodule

`default_nettype wire

// File: hdl/cmd_bank_ram.sv
/*
 * command bank, 1K x 32
 * written by software, registered read that holds while not enabled
 */
`timescale 1ns/10ps
`default_nettype none

module cmd_bank_ram import mcseq_pkg::*; (
    input  logic                  mclk,
    input  logic                  we_i,
    input  logic [CMD_ADDR_W-1:0] waddr_i,
    input  cmd_word_t             wdata_i,
    input  logic                  rd_en_i,
    input  logic [CMD_ADDR_W-1:0] raddr_i,
    output cmd_word_t             rdata_o
);

    logic [CMD_WORD_W-1:0] mem [2**CMD_ADDR_W];

    always_ff @(posedge mclk) begin
        if (we_i) mem[waddr_i] <= wdata_i;
        if (rd_en_i) rdata_o <= cmd_word_t'(mem[raddr_i]);  // last word kept otherwise
    end

endmodule

`default_nettype wire

// File: hdl/cmd_deser.sv
/*
 * byte-serial command deserializer
 * assembles address low/high and data bytes after the strobe and flags
 * the commands that fall into one address group
 */
`timescale 1ns/10ps
`default_nettype none

module cmd_deser #(
    parameter logic [10:0] ADDR       = 11'h000, // group base
    parameter logic [10:0] MASK       = 11'h7ff, // group mask
    parameter int          NUM_CYCLES = 2        // 2: address only, 4: 16-bit data
) (
    input  logic        mclk,
    input  logic        mrst,
    input  logic [7:0]  cmd_ad_i,   // AL, AH, D0, D1
    input  logic        cmd_stb_i,  // with AL
    output logic [3:0]  addr_o,     // low address bits, register select
    output logic [15:0] data_o,
    output logic        we_o        // cycle after the last byte
);

    logic [3:0]  stb_sr;  // one-hot byte position
    logic [10:0] addr_r;
    logic [15:0] data_r;

    always_ff @(posedge mclk) begin
        if (mrst) begin
            stb_sr <= '0;
            addr_r <= '0;
            data_r <= '0;
        end else begin
            stb_sr <= {stb_sr[2:0], cmd_stb_i};
            if (cmd_stb_i) addr_r[7:0] <= cmd_ad_i;   // address low
            if (stb_sr[0]) addr_r[10:8] <= cmd_ad_i[2:0]; // address high
            if (NUM_CYCLES > 2 && stb_sr[1]) data_r[7:0] <= cmd_ad_i;
            if (NUM_CYCLES > 2 && stb_sr[2]) data_r[15:8] <= cmd_ad_i;
        end
    end

    // all bytes are in once the strobe reaches the last position
    assign we_o   = stb_sr[NUM_CYCLES-1] && ((addr_r & MASK) == ADDR);
    assign addr_o = addr_r[3:0];
    assign data_o = data_r;  // stays zero in the address-only group

endmodule

`default_nettype wire

// File: hdl/cmd_word_decode.sv
/*
 * command word decoder
 * picks the active bank word, splits out the sequencing fields and
 * registers the DDR pins and buffer strobes
 */
`timescale 1ns/10ps
`default_nettype none

module cmd_word_decode import mcseq_pkg::*; (
    input  logic                      mclk,
    input  logic                      mrst,
    input  cmd_word_t [NUM_BANKS-1:0] bank_words_i,
    input  logic                      bank_sel_i,
    input  logic                      word_valid_i,
    input  logic                      cmda_en_i,
    output cmd_fields_t               fields_o,   // same cycle, to fetch control
    output ddr_cmd_t                  ddr_cmd_o,
    output logic                      buf_rd_o,
    output logic                      buf_rst_o,
    output logic                      buf_wr_o    // before the write delay
);

    cmd_word_t word;
    logic      cmd_on;

    assign word = word_valid_i ? bank_words_i[bank_sel_i] : '0;  // stale words dropped

    assign fields_o.nop       = (word.op == OP_NOP);
    assign fields_o.add_pause = word.add_pause;
    assign fields_o.pause_len = word.addr[PAUSE_W-1:0];
    assign fields_o.done      = fields_o.nop && word.addr[PAUSE_W];  // just above length
    assign fields_o.buf_rd    = word.buf_rd;
    assign fields_o.buf_wr    = word.buf_wr;
    assign fields_o.buf_rst   = word.buf_rst;

    assign cmd_on = word_valid_i && !fields_o.nop && cmda_en_i;

    always_ff @(posedge mclk) begin
        if (mrst) begin
            ddr_cmd_o.op   <= OP_NOP;
            ddr_cmd_o.ba   <= '0;
            ddr_cmd_o.addr <= '0;
            ddr_cmd_o.odt  <= 1'b0;
            buf_rd_o       <= 1'b0;
            buf_rst_o      <= 1'b0;
            buf_wr_o       <= 1'b0;
        end else begin
            ddr_cmd_o.op   <= cmd_on ? word.op : OP_NOP;
            ddr_cmd_o.ba   <= cmd_on ? word.ba : '0;
            ddr_cmd_o.addr <= cmd_on ? word.addr : '0;  // pause length kept off the pins
            ddr_cmd_o.odt  <= cmda_en_i && word.odt;
            buf_rd_o       <= fields_o.buf_rd;
            buf_rst_o      <= fields_o.buf_rst;
            buf_wr_o       <= fields_o.buf_wr;
        end
    end

endmodule

`default_nettype wire

// File: hdl/mcseq_pkg.sv
/*
 * mcseq shared definitions
 * widths, programming map, DDR opcodes and the structs passed between
 * the sequencer blocks
 */
`default_nettype none

package mcseq_pkg;

    localparam int CMD_ADDR_W = 10;  // 1K words per bank
    localparam int NUM_BANKS  = 2;   // software bank and auto bank
    localparam int CMD_WORD_W = 32;
    localparam int PAUSE_W    = 10;  // pause length in NOP address bits
    localparam int DDR_ADDR_W = 15;  // row/column address, 4Gb part
    localparam int CHN_W      = 4;   // up to 16 buffer channels

    localparam logic [10:0] MAP_0BIT_ADDR  = 11'h020; // set/clear flags
    localparam logic [10:0] MAP_0BIT_MASK  = 11'h7f0;
    localparam logic [10:0] MAP_16BIT_ADDR = 11'h050; // 16-bit registers
    localparam logic [10:0] MAP_16BIT_MASK = 11'h7f8;

    localparam logic [3:0] DFLT_WBUF_DELAY = 4'd8;

    // selector in address bits 3:1, new value in bit 0
    typedef enum logic [2:0] {
        FLAG_CMDA_EN   = 3'd2,  // command/address outputs on
        FLAG_SDRST_ACT = 3'd3,  // memory reset active
        FLAG_CKE_EN    = 3'd4   // clock enable to memory
    } flag_sel_e;

    typedef enum logic [2:0] {
        REG_WBUF_DELAY = 3'd2   // extra write strobe delay, bits 3:0
    } reg16_sel_e;

    // {ras, cas, we}, active low
    typedef enum logic [2:0] {
        OP_NOP = 3'b111,
        OP_ACT = 3'b011,
        OP_RD  = 3'b101,
        OP_WR  = 3'b100,
        OP_PRE = 3'b010,
        OP_REF = 3'b001,
        OP_MRS = 3'b000
    } ddr_op_e;

    typedef struct packed {
        ddr_op_e               op;
        logic [2:0]            ba;
        logic [DDR_ADDR_W-1:0] addr;      // NOP: 9:0 pause, 10 done
        logic                  odt;
        logic                  buf_rd;
        logic                  buf_wr;
        logic                  buf_rst;   // next buffer page
        logic                  add_pause; // one NOP after this word
        logic [5:0]            spare;
    } cmd_word_t;

    typedef struct packed {
        logic               nop;
        logic               add_pause;
        logic [PAUSE_W-1:0] pause_len;
        logic               done;
        logic               buf_rd;
        logic               buf_wr;
        logic               buf_rst;
    } cmd_fields_t;

    typedef struct packed {
        ddr_op_e               op;
        logic [2:0]            ba;
        logic [DDR_ADDR_W-1:0] addr;
        logic                  odt;
    } ddr_cmd_t;

    typedef struct packed {
        logic cmda_en;
        logic ddr_rst;  // high resets memory and sequencer
        logic cke;
    } ddr_ctrl_t;

    typedef struct packed {
        logic                  we;
        logic                  bank;
        logic [CMD_ADDR_W-1:0] addr;
        cmd_word_t             data;
    } bank_wr_t;

    typedef struct packed {
        logic [CHN_W-1:0] chn;
    } buf_tag_t;

endpackage

`default_nettype wire

// File: hdl/mcseq_top.sv
/*
 * DDR3 command sequencer top
 * programming channel, control registers, two command banks, fetch and
 * decode, delayed write buffer strobes
 */
`timescale 1ns/10ps
`default_nettype none

module mcseq_top import mcseq_pkg::*; (
    input  logic                mclk,
    input  logic                mrst,
    input  logic [7:0]          cmd_ad_i,
    input  logic                cmd_stb_i,
    input  bank_wr_t            bank_wr_i,
    input  logic                run_seq_i,
    input  logic [CMD_ADDR_W:0] run_addr_i,
    input  buf_tag_t            run_chn_i,
    output logic                run_busy_o,
    output logic                run_done_o,
    output logic                mcontr_reset_o,
    output ddr_cmd_t            ddr_cmd_o,
    output ddr_ctrl_t           ddr_ctrl_o,
    output logic                buf_rd_o,
    output logic                buf_rpage_nxt_o,
    output buf_tag_t            buf_rchn_o,      // channel of the current run
    output logic                buf_wr_o,
    output logic                buf_wpage_nxt_o,
    output buf_tag_t            buf_wchn_o
);

    logic [3:0]                flag_addr;
    logic                      flag_we;
    logic [3:0]                reg_addr;
    logic [15:0]               reg_data;
    logic                      reg_we;
    logic [3:0]                wbuf_delay;
    logic [NUM_BANKS-1:0]      rd_en;
    logic [CMD_ADDR_W-1:0]     rd_addr;
    logic                      bank_sel;
    logic                      word_valid;
    cmd_word_t [NUM_BANKS-1:0] bank_words;
    cmd_fields_t               fields;
    logic                      buf_wr_ndly;  // aligned with ddr_cmd_o

    cmd_deser #(.ADDR(MAP_0BIT_ADDR), .MASK(MAP_0BIT_MASK), .NUM_CYCLES(2)) u_deser_0bit (
        .mclk      (mclk),
        .mrst      (mrst),
        .cmd_ad_i  (cmd_ad_i),
        .cmd_stb_i (cmd_stb_i),
        .addr_o    (flag_addr),
        .data_o    (),           // no data bytes in this group
        .we_o      (flag_we)
    );

    cmd_deser #(.ADDR(MAP_16BIT_ADDR), .MASK(MAP_16BIT_MASK), .NUM_CYCLES(4)) u_deser_16bit (
        .mclk      (mclk),
        .mrst      (mrst),
        .cmd_ad_i  (cmd_ad_i),
        .cmd_stb_i (cmd_stb_i),
        .addr_o    (reg_addr),
        .data_o    (reg_data),
        .we_o      (reg_we)
    );

    phy_ctrl_regs u_ctrl_regs (
        .mclk         (mclk),
        .mrst         (mrst),
        .flag_we_i    (flag_we),
        .flag_addr_i  (flag_addr),
        .reg_we_i     (reg_we),
        .reg_addr_i   (reg_addr),
        .reg_data_i   (reg_data),
        .ctrl_o       (ddr_ctrl_o),
        .wbuf_delay_o (wbuf_delay)
    );

    assign mcontr_reset_o = ddr_ctrl_o.ddr_rst;  // also clears the sequencer

    seq_fetch_ctrl u_fetch (
        .mclk         (mclk),
        .mrst         (mrst),
        .ddr_rst_i    (ddr_ctrl_o.ddr_rst),
        .run_seq_i    (run_seq_i),
        .run_addr_i   (run_addr_i),
        .fields_i     (fields),
        .rd_en_o      (rd_en),
        .rd_addr_o    (rd_addr),
        .bank_sel_o   (bank_sel),
        .word_valid_o (word_valid),
        .busy_o       (run_busy_o),
        .done_o       (run_done_o)
    );

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        cmd_bank_ram u_bank (
            .mclk    (mclk),
            .we_i    (bank_wr_i.we && bank_wr_i.bank == 1'(i)),  // bank index decode
            .waddr_i (bank_wr_i.addr),
            .wdata_i (bank_wr_i.data),
            .rd_en_i (rd_en[i]),
            .raddr_i (rd_addr),
            .rdata_o (bank_words[i])
        );
    end

    cmd_word_decode u_decode (
        .mclk         (mclk),
        .mrst         (mrst),
        .bank_words_i (bank_words),
        .bank_sel_i   (bank_sel),
        .word_valid_i (word_valid),
        .cmda_en_i    (ddr_ctrl_o.cmda_en),
        .fields_o     (fields),
        .ddr_cmd_o    (ddr_cmd_o),
        .buf_rd_o     (buf_rd_o),
        .buf_rst_o    (buf_rpage_nxt_o),
        .buf_wr_o     (buf_wr_ndly)
    );

    always_ff @(posedge mclk) begin
        if (mrst) buf_rchn_o <= '0;
        else if (run_seq_i) buf_rchn_o <= run_chn_i;  // held for the whole run
    end

    buf_wr_delay u_wr_delay (
        .mclk    (mclk),
        .mrst    (mrst),
        .delay_i (wbuf_delay),
        .wr_i    (buf_wr_ndly),
        .rst_i   (buf_rpage_nxt_o),
        .tag_i   (buf_rchn_o),
        .wr_o    (buf_wr_o),
        .rst_o   (buf_wpage_nxt_o),
        .tag_o   (buf_wchn_o)
    );

endmodule

`default_nettype wire

// File: hdl/phy_ctrl_regs.sv
/*
 * memory control flags and write buffer delay
 * flags set or cleared by 0-bit commands, delay loaded by 16-bit command
 */
`timescale 1ns/10ps
`default_nettype none

module phy_ctrl_regs import mcseq_pkg::*; (
    input  logic        mclk,
    input  logic        mrst,
    input  logic        flag_we_i,
    input  logic [3:0]  flag_addr_i,   // 3:1 selector, 0 new value
    input  logic        reg_we_i,
    input  logic [3:0]  reg_addr_i,
    input  logic [15:0] reg_data_i,
    output ddr_ctrl_t   ctrl_o,
    output logic [3:0]  wbuf_delay_o
);

    always_ff @(posedge mclk) begin
        if (mrst) begin
            ctrl_o.cmda_en <= 1'b0;
            ctrl_o.ddr_rst <= 1'b1;  // memory held in reset until released
            ctrl_o.cke     <= 1'b0;
        end else if (flag_we_i) begin
            case (flag_addr_i[3:1])
                FLAG_CMDA_EN:   ctrl_o.cmda_en <= flag_addr_i[0];
                FLAG_SDRST_ACT: ctrl_o.ddr_rst <= flag_addr_i[0];
                FLAG_CKE_EN:    ctrl_o.cke     <= flag_addr_i[0];
                default: ;  // unused selectors
            endcase
        end
    end

    always_ff @(posedge mclk) begin
        if (mrst) begin
            wbuf_delay_o <= DFLT_WBUF_DELAY;
        end else if (reg_we_i) begin
            case (reg_addr_i[2:0])
                REG_WBUF_DELAY: wbuf_delay_o <= reg_data_i[3:0];
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/seq_fetch_ctrl.sv
/*
 * command fetch controller
 * runs the bank read address from the start word, holds reads for pauses
 * and ends the sequence on the done word
 */
`timescale 1ns/10ps
`default_nettype none

module seq_fetch_ctrl import mcseq_pkg::*; (
    input  logic                  mclk,
    input  logic                  mrst,
    input  logic                  ddr_rst_i,    // aborts the run
    input  logic                  run_seq_i,
    input  logic [CMD_ADDR_W:0]   run_addr_i,   // msb selects the bank
    input  cmd_fields_t           fields_i,     // decoded current word
    output logic [NUM_BANKS-1:0]  rd_en_o,
    output logic [CMD_ADDR_W-1:0] rd_addr_o,
    output logic                  bank_sel_o,
    output logic                  word_valid_o, // bank output is a fresh word
    output logic                  busy_o,
    output logic                  done_o
);

    logic [PAUSE_W-1:0] word_pause;  // idle cycles requested by current word
    logic [PAUSE_W-1:0] pause_cnt;   // idle cycles still to go after the first
    logic               hold;
    logic               seq_end;
    logic               rd_go;

    // a NOP length wins over add_pause
    assign word_pause = (fields_i.nop && fields_i.pause_len != '0) ?
                        fields_i.pause_len : PAUSE_W'(fields_i.add_pause);

    // hold is taken from the word itself, so the next word is never fetched early
    assign hold    = word_valid_o ? (word_pause != '0) : (pause_cnt != '0);
    assign seq_end = word_valid_o && fields_i.done;  // pause length ignored
    assign rd_go   = busy_o && !hold && !seq_end && !ddr_rst_i;
    assign rd_en_o = rd_go ? (NUM_BANKS'(1) << bank_sel_o) : '0;  // one-hot

    always_ff @(posedge mclk) begin
        if (mrst || ddr_rst_i) begin
            busy_o       <= 1'b0;
            done_o       <= 1'b0;  // no done on abort
            word_valid_o <= 1'b0;
            pause_cnt    <= '0;
        end else begin
            done_o       <= seq_end;
            word_valid_o <= rd_go;  // registered read, valid next cycle
            if (seq_end) busy_o <= 1'b0;
            else if (run_seq_i) busy_o <= 1'b1;
            if (seq_end) begin
                pause_cnt <= '0;
            end else if (word_valid_o && word_pause != '0) begin
                pause_cnt <= word_pause - 1'b1;  // first idle cycle is this one
            end else if (pause_cnt != '0) begin
                pause_cnt <= pause_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (mrst) begin
            rd_addr_o  <= '0;
            bank_sel_o <= 1'b0;
        end else if (run_seq_i) begin
            rd_addr_o  <= run_addr_i[CMD_ADDR_W-1:0];
            bank_sel_o <= run_addr_i[CMD_ADDR_W];
        end else if (rd_go) begin
            rd_addr_o  <= rd_addr_o + 1'b1;
        end
    end

endmodule

`default_nettype wire
